//--- decode.sv
// Branches and jumps resolve here; loads, stores, system ops and bad encodings decode as NOPs
`timescale 1ns/1ns

module decode (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [rv_pkg::XLEN-1:0] pc_i,
    input  logic [rv_pkg::XLEN-1:0] inst_i,
    input  logic [rv_pkg::XLEN-1:0] rs1_value_i,
    input  logic [rv_pkg::XLEN-1:0] rs2_value_i,
    output logic [4:0]              rs1_addr_o,
    output logic [4:0]              rs2_addr_o,
    output logic                    redirect_o,
    output logic [rv_pkg::XLEN-1:0] redirect_pc_o,
    id_ex_if.producer               ex
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [4:0] rd;

    logic [rv_pkg::XLEN-1:0] imm_i;
    logic [rv_pkg::XLEN-1:0] imm_u;
    logic [rv_pkg::XLEN-1:0] imm_b;
    logic [rv_pkg::XLEN-1:0] imm_j;
    logic [rv_pkg::XLEN-1:0] imm_sh;
    logic [rv_pkg::XLEN-1:0] jalr_sum;

    logic branch_taken;

    rv_pkg::alu_op_e         alu_op_d;
    rv_pkg::opsel_e          opsel1_d;
    rv_pkg::opsel_e          opsel2_d;
    rv_pkg::wbsel_e          wbsel_d;
    logic                    rf_w_en_d;
    logic [rv_pkg::XLEN-1:0] imm_d;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign rd     = inst_i[11:7];

    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];

    assign imm_i  = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_u  = {inst_i[31:12], 12'b0};
    assign imm_b  = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j  = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21],
                     1'b0};
    assign imm_sh = {27'b0, inst_i[24:20]};

    assign jalr_sum = rs1_value_i + imm_i;

    always_comb begin
        case (funct3)
            rv_pkg::F3_BEQ:  branch_taken = (rs1_value_i == rs2_value_i);
            rv_pkg::F3_BNE:  branch_taken = (rs1_value_i != rs2_value_i);
            rv_pkg::F3_BLT:  branch_taken = ($signed(rs1_value_i) < $signed(rs2_value_i));
            rv_pkg::F3_BGE:  branch_taken = ($signed(rs1_value_i) >= $signed(rs2_value_i));
            rv_pkg::F3_BLTU: branch_taken = (rs1_value_i < rs2_value_i);
            rv_pkg::F3_BGEU: branch_taken = (rs1_value_i >= rs2_value_i);
            default:         branch_taken = 1'b0;
        endcase
    end

    always_comb begin
        // Default is a no-op that writes nothing
        alu_op_d      = rv_pkg::ALU_NOP;
        opsel1_d      = rv_pkg::OPSEL_RS1;
        opsel2_d      = rv_pkg::OPSEL_RS2;
        wbsel_d       = rv_pkg::WB_ALU;
        rf_w_en_d     = 1'b0;
        imm_d         = '0;
        redirect_o    = 1'b0;
        redirect_pc_o = pc_i + imm_b;

        case (opcode)
            rv_pkg::OP_RTYPE: begin
                rf_w_en_d = 1'b1;
                case ({funct7, funct3})
                    {rv_pkg::F7_BASE, rv_pkg::F3_ADD_SUB}: alu_op_d = rv_pkg::ALU_ADD;
                    {rv_pkg::F7_ALT,  rv_pkg::F3_ADD_SUB}: alu_op_d = rv_pkg::ALU_SUB;
                    {rv_pkg::F7_BASE, rv_pkg::F3_SLL}:     alu_op_d = rv_pkg::ALU_SLL;
                    {rv_pkg::F7_BASE, rv_pkg::F3_SLT}:     alu_op_d = rv_pkg::ALU_SLT;
                    {rv_pkg::F7_BASE, rv_pkg::F3_SLTU}:    alu_op_d = rv_pkg::ALU_SLTU;
                    {rv_pkg::F7_BASE, rv_pkg::F3_XOR}:     alu_op_d = rv_pkg::ALU_XOR;
                    {rv_pkg::F7_BASE, rv_pkg::F3_SR}:      alu_op_d = rv_pkg::ALU_SRL;
                    {rv_pkg::F7_ALT,  rv_pkg::F3_SR}:      alu_op_d = rv_pkg::ALU_SRA;
                    {rv_pkg::F7_BASE, rv_pkg::F3_OR}:      alu_op_d = rv_pkg::ALU_OR;
                    {rv_pkg::F7_BASE, rv_pkg::F3_AND}:     alu_op_d = rv_pkg::ALU_AND;
                    default:                               rf_w_en_d = 1'b0;
                endcase
            end
            rv_pkg::OP_ITYPE: begin
                opsel2_d  = rv_pkg::OPSEL_IMM;
                imm_d     = imm_i;
                rf_w_en_d = 1'b1;
                case (funct3)
                    rv_pkg::F3_ADD_SUB: alu_op_d = rv_pkg::ALU_ADD;
                    rv_pkg::F3_SLT:     alu_op_d = rv_pkg::ALU_SLT;
                    rv_pkg::F3_SLTU:    alu_op_d = rv_pkg::ALU_SLTU;
                    rv_pkg::F3_XOR:     alu_op_d = rv_pkg::ALU_XOR;
                    rv_pkg::F3_OR:      alu_op_d = rv_pkg::ALU_OR;
                    rv_pkg::F3_AND:     alu_op_d = rv_pkg::ALU_AND;
                    rv_pkg::F3_SLL: begin
                        imm_d     = imm_sh;
                        alu_op_d  = rv_pkg::ALU_SLL;
                        rf_w_en_d = (funct7 == rv_pkg::F7_BASE);
                    end
                    default: begin
                        // Shift right immediate, funct7 picks logical or arithmetic
                        imm_d     = imm_sh;
                        alu_op_d  = (funct7 == rv_pkg::F7_ALT) ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                        rf_w_en_d = (funct7 == rv_pkg::F7_BASE) || (funct7 == rv_pkg::F7_ALT);
                    end
                endcase
            end
            rv_pkg::OP_LUI: begin
                wbsel_d   = rv_pkg::WB_IMM;
                imm_d     = imm_u;
                rf_w_en_d = 1'b1;
            end
            rv_pkg::OP_AUIPC: begin
                alu_op_d  = rv_pkg::ALU_ADD;
                opsel1_d  = rv_pkg::OPSEL_PC;
                opsel2_d  = rv_pkg::OPSEL_IMM;
                imm_d     = imm_u;
                rf_w_en_d = 1'b1;
            end
            rv_pkg::OP_JAL: begin
                wbsel_d       = rv_pkg::WB_PC4;
                rf_w_en_d     = 1'b1;
                redirect_o    = 1'b1;
                redirect_pc_o = pc_i + imm_j;
            end
            rv_pkg::OP_JALR: begin
                if (funct3 == 3'b000) begin
                    wbsel_d       = rv_pkg::WB_PC4;
                    rf_w_en_d     = 1'b1;
                    redirect_o    = 1'b1;
                    redirect_pc_o = {jalr_sum[rv_pkg::XLEN-1:1], 1'b0};
                end
            end
            rv_pkg::OP_BRANCH: begin
                redirect_o = branch_taken;
            end
            default: begin
            end
        endcase
    end

    // ID/EX register
    always_ff @(posedge clk) begin
        if (reset) begin
            ex.pc      <= '0;
            ex.alu_op  <= rv_pkg::ALU_ADD;
            ex.opsel1  <= rv_pkg::OPSEL_RS1;
            ex.opsel2  <= rv_pkg::OPSEL_RS2;
            ex.wbsel   <= rv_pkg::WB_ALU;
            ex.rd      <= '0;
            ex.rf_w_en <= 1'b0;
            ex.imm     <= '0;
            ex.rs1_val <= '0;
            ex.rs2_val <= '0;
        end else begin
            ex.pc      <= pc_i;
            ex.alu_op  <= alu_op_d;
            ex.opsel1  <= opsel1_d;
            ex.opsel2  <= opsel2_d;
            ex.wbsel   <= wbsel_d;
            ex.rd      <= rd;
            ex.rf_w_en <= rf_w_en_d;
            ex.imm     <= imm_d;
            ex.rs1_val <= rs1_value_i;
            ex.rs2_val <= rs2_value_i;
        end
    end

endmodule

//--- execute.sv
// Purely combinational stage; the register write lands at the next clock edge
`timescale 1ns/1ns

module execute (
    input  logic                    clk,
    input  logic                    reset,
    id_ex_if.consumer               ex,
    output logic                    wb_en_o,
    output logic [4:0]              wb_addr_o,
    output logic [rv_pkg::XLEN-1:0] wb_data_o
);

    // Stage has no state of its own; clk and reset only keep the stage ports alike

    logic [rv_pkg::XLEN-1:0] op1;
    logic [rv_pkg::XLEN-1:0] op2;
    logic [4:0]              shamt;
    logic [rv_pkg::XLEN-1:0] alu_result;

    assign op1   = (ex.opsel1 == rv_pkg::OPSEL_PC) ? ex.pc : ex.rs1_val;
    assign op2   = (ex.opsel2 == rv_pkg::OPSEL_IMM) ? ex.imm : ex.rs2_val;
    assign shamt = op2[4:0];

    always_comb begin
        case (ex.alu_op)
            rv_pkg::ALU_ADD:  alu_result = op1 + op2;
            rv_pkg::ALU_SUB:  alu_result = op1 - op2;
            rv_pkg::ALU_SLL:  alu_result = op1 << shamt;
            rv_pkg::ALU_SLT: begin
                alu_result = {{(rv_pkg::XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
            end
            rv_pkg::ALU_SLTU: begin
                alu_result = {{(rv_pkg::XLEN-1){1'b0}}, op1 < op2};
            end
            rv_pkg::ALU_XOR:  alu_result = op1 ^ op2;
            rv_pkg::ALU_SRL:  alu_result = op1 >> shamt;
            rv_pkg::ALU_SRA:  alu_result = $unsigned($signed(op1) >>> shamt);
            rv_pkg::ALU_OR:   alu_result = op1 | op2;
            rv_pkg::ALU_AND:  alu_result = op1 & op2;
            default:          alu_result = '0;
        endcase
    end

    always_comb begin
        case (ex.wbsel)
            rv_pkg::WB_IMM: wb_data_o = ex.imm;
            // Link value for JAL and JALR
            rv_pkg::WB_PC4: wb_data_o = ex.pc + 32'd4;
            default:        wb_data_o = alu_result;
        endcase
    end

    assign wb_en_o   = ex.rf_w_en && (ex.rd != 5'd0);
    assign wb_addr_o = ex.rd;

endmodule

//--- fetch.sv
// Instruction memory read is combinational; a redirect flushes the IF/ID slot to a NOP
`timescale 1ns/1ns

module fetch #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    redirect_i,
    input  logic [rv_pkg::XLEN-1:0] redirect_pc_i,
    input  logic [rv_pkg::XLEN-1:0] imem_data_i,
    output logic [rv_pkg::XLEN-1:0] imem_addr_o,
    output logic [rv_pkg::XLEN-1:0] if_pc_o,
    output logic [rv_pkg::XLEN-1:0] if_inst_o
);

    logic [rv_pkg::XLEN-1:0] pc_q;

    assign imem_addr_o = pc_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= RESET_PC;
        end else if (redirect_i) begin
            pc_q <= redirect_pc_i;
        end else begin
            pc_q <= pc_q + 32'd4;
        end
    end

    // IF/ID register
    always_ff @(posedge clk) begin
        if (reset) begin
            if_inst_o <= rv_pkg::NOP_INST;
            if_pc_o   <= RESET_PC;
        end else begin
            if_pc_o <= pc_q;
            // Wrong-path instruction behind a taken branch or jump
            if (redirect_i)
                if_inst_o <= rv_pkg::NOP_INST;
            else
                if_inst_o <= imem_data_i;
        end
    end

endmodule

//--- id_ex_if.sv
// Decoded bundle from decode to execute; no handshake, rf_w_en low marks a bubble
`timescale 1ns/1ns

interface id_ex_if;

    logic [rv_pkg::XLEN-1:0] pc;
    rv_pkg::alu_op_e         alu_op;
    rv_pkg::opsel_e          opsel1;
    rv_pkg::opsel_e          opsel2;
    rv_pkg::wbsel_e          wbsel;
    logic [4:0]              rd;
    logic                    rf_w_en;
    logic [rv_pkg::XLEN-1:0] imm;
    logic [rv_pkg::XLEN-1:0] rs1_val;
    logic [rv_pkg::XLEN-1:0] rs2_val;

    modport producer (
        output pc, alu_op, opsel1, opsel2, wbsel, rd, rf_w_en, imm, rs1_val, rs2_val
    );

    modport consumer (
        input pc, alu_op, opsel1, opsel2, wbsel, rd, rf_w_en, imm, rs1_val, rs2_val
    );

endinterface

//--- reg_file.sv
// x0 reads zero and ignores writes; a read of the register being written returns the new value
`timescale 1ns/1ns

module reg_file (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [4:0]              rs1_addr_i,
    input  logic [4:0]              rs2_addr_i,
    input  logic                    wb_en_i,
    input  logic [4:0]              wb_addr_i,
    input  logic [rv_pkg::XLEN-1:0] wb_data_i,
    output logic [rv_pkg::XLEN-1:0] rs1_data_o,
    output logic [rv_pkg::XLEN-1:0] rs2_data_o
);

    logic [rv_pkg::XLEN-1:0] regs [1:31];

    // Read port with write-through bypass
    function automatic logic [rv_pkg::XLEN-1:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0)
            return '0;
        else if (wb_en_i && (wb_addr_i == addr))
            return wb_data_i;
        else
            return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (wb_en_i && (wb_addr_i != 5'd0)) begin
            regs[wb_addr_i] <= wb_data_i;
        end
    end

    assign rs1_data_o = read_port(rs1_addr_i);
    assign rs2_data_o = read_port(rs2_addr_i);

endmodule

//--- run.sh
#!/bin/sh
# Build and run with Verilator; a failure line in the log fails the script
verilator --binary --timing --assert -f tb.f --top-module tb_rv_core -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log && exit 1 || exit 0

//--- rv_core.sv
// Three-stage RV32I subset core; no stalls, no loads or stores, one bubble per taken redirect
`timescale 1ns/1ns

module rv_core #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                    clk,
    input  logic                    reset,
    output logic [rv_pkg::XLEN-1:0] imem_addr_o,
    input  logic [rv_pkg::XLEN-1:0] imem_data_i,
    output logic                    wb_en_o,
    output logic [4:0]              wb_addr_o,
    output logic [rv_pkg::XLEN-1:0] wb_data_o
);

    logic [rv_pkg::XLEN-1:0] if_pc;
    logic [rv_pkg::XLEN-1:0] if_inst;
    logic                    redirect;
    logic [rv_pkg::XLEN-1:0] redirect_pc;
    logic [4:0]              rs1_addr;
    logic [4:0]              rs2_addr;
    logic [rv_pkg::XLEN-1:0] rs1_data;
    logic [rv_pkg::XLEN-1:0] rs2_data;

    id_ex_if id_ex ();

    fetch #(.RESET_PC(RESET_PC)) u_fetch (
        .clk(clk), .reset(reset),
        .redirect_i(redirect), .redirect_pc_i(redirect_pc),
        .imem_data_i(imem_data_i), .imem_addr_o(imem_addr_o),
        .if_pc_o(if_pc), .if_inst_o(if_inst)
    );

    decode u_decode (
        .clk(clk), .reset(reset),
        .pc_i(if_pc), .inst_i(if_inst),
        .rs1_value_i(rs1_data), .rs2_value_i(rs2_data),
        .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
        .redirect_o(redirect), .redirect_pc_o(redirect_pc),
        .ex(id_ex.producer)
    );

    reg_file u_reg_file (
        .clk(clk), .reset(reset),
        .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
        .wb_en_i(wb_en_o), .wb_addr_i(wb_addr_o), .wb_data_i(wb_data_o),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
    );

    // Writeback nets feed the register file and the top-level ports alike
    execute u_execute (
        .clk(clk), .reset(reset),
        .ex(id_ex.consumer),
        .wb_en_o(wb_en_o), .wb_addr_o(wb_addr_o), .wb_data_o(wb_data_o)
    );

endmodule

//--- rv_pkg.sv
// RV32I subset only (ALU, LUI, AUIPC, JAL, JALR, branches); width fixed at 32
package rv_pkg;

    parameter int XLEN = 32;

    // ADDI x0, x0, 0
    parameter logic [XLEN-1:0] NOP_INST = 32'h0000_0013;

    typedef enum logic [6:0] {
        OP_RTYPE  = 7'b0110011,
        OP_ITYPE  = 7'b0010011,
        OP_BRANCH = 7'b1100011,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111
    } opcode_e;

    // ALU funct3, shared by register and immediate forms
    parameter logic [2:0] F3_ADD_SUB = 3'b000;
    parameter logic [2:0] F3_SLL     = 3'b001;
    parameter logic [2:0] F3_SLT     = 3'b010;
    parameter logic [2:0] F3_SLTU    = 3'b011;
    parameter logic [2:0] F3_XOR     = 3'b100;
    parameter logic [2:0] F3_SR      = 3'b101;
    parameter logic [2:0] F3_OR      = 3'b110;
    parameter logic [2:0] F3_AND     = 3'b111;

    // Branch funct3
    parameter logic [2:0] F3_BEQ  = 3'b000;
    parameter logic [2:0] F3_BNE  = 3'b001;
    parameter logic [2:0] F3_BLT  = 3'b100;
    parameter logic [2:0] F3_BGE  = 3'b101;
    parameter logic [2:0] F3_BLTU = 3'b110;
    parameter logic [2:0] F3_BGEU = 3'b111;

    // Base form and alternate form (SUB, SRA, SRAI)
    parameter logic [6:0] F7_BASE = 7'b0000000;
    parameter logic [6:0] F7_ALT  = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9,
        ALU_NOP  = 4'd10
    } alu_op_e;

    // Operand 1 uses RS1 or PC, operand 2 uses RS2 or IMM
    typedef enum logic [1:0] {
        OPSEL_RS1 = 2'd0,
        OPSEL_PC  = 2'd1,
        OPSEL_RS2 = 2'd2,
        OPSEL_IMM = 2'd3
    } opsel_e;

    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_IMM = 2'd1,
        WB_PC4 = 2'd2
    } wbsel_e;

endpackage

//--- tb.f
rv_pkg.sv
id_ex_if.sv
reg_file.sv
fetch.sv
decode.sv
execute.sv
rv_core.sv
tb_rv_core.sv

//--- tb_rv_core.sv
// Programs are loaded at address 0 and branch only forward; needs a simulator with timing support
`timescale 1ns/1ns

module tb_rv_core;

    localparam logic [31:0] RESET_PC   = 32'h0000_0000;
    localparam logic [6:0]  OPC_OP     = 7'b0110011;
    localparam logic [6:0]  OPC_OPI    = 7'b0010011;
    localparam logic [6:0]  OPC_LUI    = 7'b0110111;
    localparam logic [6:0]  OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0]  OPC_JAL    = 7'b1101111;
    localparam logic [6:0]  OPC_JALR   = 7'b1100111;
    localparam logic [6:0]  OPC_BRANCH = 7'b1100011;
    localparam int N_RANDOM = 40;
    // Words of all six programs; each word may cost a bubble, plus reset and drain per test
    localparam int TOTAL_WORDS = 3 + (12 + N_RANDOM) + 10 + 38 + 12 + 14;
    localparam int WATCHDOG_CYCLES = 2 * TOTAL_WORDS + 16 * 6 + 50;

    logic        clk;
    logic        reset;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic        wb_en;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;

    logic [31:0] imem [0:255];
    logic [36:0] exp_wb [$];
    logic [31:0] exp_addr [$];
    int          plen;
    int          errors;
    int          tests_run;
    int          tests_failed;
    integer      seed;

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        // custom-0 opcode, decodes as a no-op
        return {addr[31:7] ^ addr[24:0], 7'b0001011};
    endfunction

    assign imem_data = (imem_addr < 32'd1024) ? imem[imem_addr[9:2]] : fill_word(imem_addr);

    rv_core #(.RESET_PC(RESET_PC)) DUT (
        .clk(clk), .reset(reset),
        .imem_addr_o(imem_addr), .imem_data_i(imem_data),
        .wb_en_o(wb_en), .wb_addr_o(wb_addr), .wb_data_o(wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_u(input logic [6:0] opc, input logic [4:0] rd,
                                          input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    // Spec ALU for register and immediate forms; alt selects SUB or SRA
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: return (a < b) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b101: begin
                if (alt)
                    return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic start_program();
        for (int i = 0; i < 256; i++)
            imem[i[7:0]] = fill_word({i[29:0], 2'b00});
        plen = 0;
    endtask

    task automatic put(input logic [31:0] inst);
        imem[plen[7:0]] = inst;
        plen++;
    endtask

    task automatic put_random_alu();
        logic [31:0] r1;
        logic [31:0] r2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        r1 = $random(seed);
        r2 = $random(seed);
        f3 = r1[17:15];
        f7 = (r1[19] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
        if (r1[18])
            put(enc_r(f7, f3, r1[4:0], r1[9:5], r1[14:10]));
        else if (f3 == 3'b001 || f3 == 3'b101)
            put(enc_i(OPC_OPI, f3, r1[4:0], r1[9:5], {f7, r2[4:0]}));
        else
            put(enc_i(OPC_OPI, f3, r1[4:0], r1[9:5], r2[11:0]));
    endtask

    // Branch over one increment of x20; x21 counts every pass
    task automatic put_branch_trio(input logic [2:0] f3, input logic [4:0] rs1,
                                   input logic [4:0] rs2);
        put(enc_b(f3, rs1, rs2, 13'd8));
        put(enc_i(OPC_OPI, 3'b000, 5'd20, 5'd20, 12'd1));
        put(enc_i(OPC_OPI, 3'b000, 5'd21, 5'd21, 12'd1));
    endtask

    // Instruction-level model fills the expected writeback and fetch address queues
    task automatic run_model(input int len);
        logic [31:0] x [0:31];
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] res;
        logic [31:0] next_pc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic        wr;
        logic        taken;
        int          steps;
        for (int i = 0; i < 32; i++)
            x[i[4:0]] = '0;
        pc = RESET_PC;
        steps = 0;
        while (pc < len * 4 && steps < 4 * len) begin
            inst = imem[pc[9:2]];
            f3 = inst[14:12];
            f7 = inst[31:25];
            a = x[inst[19:15]];
            b = x[inst[24:20]];
            imm_i = {{20{inst[31]}}, inst[31:20]};
            wr = 1'b0;
            taken = 1'b0;
            res = '0;
            next_pc = pc + 32'd4;
            exp_addr.push_back(pc);
            case (inst[6:0])
                OPC_OP: begin
                    wr = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
                    res = alu_ref(f3, f7[5], a, b);
                end
                OPC_OPI: begin
                    if (f3 == 3'b001) begin
                        wr = (f7 == 7'h00);
                        res = a << inst[24:20];
                    end else if (f3 == 3'b101) begin
                        wr = (f7 == 7'h00) || (f7 == 7'h20);
                        res = alu_ref(f3, f7[5], a, {27'd0, inst[24:20]});
                    end else begin
                        wr = 1'b1;
                        res = alu_ref(f3, 1'b0, a, imm_i);
                    end
                end
                OPC_LUI: begin
                    wr = 1'b1;
                    res = {inst[31:12], 12'd0};
                end
                OPC_AUIPC: begin
                    wr = 1'b1;
                    res = pc + {inst[31:12], 12'd0};
                end
                OPC_JAL: begin
                    wr = 1'b1;
                    taken = 1'b1;
                    res = pc + 32'd4;
                    next_pc = pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                                    inst[30:21], 1'b0};
                end
                OPC_JALR: begin
                    if (f3 == 3'b000) begin
                        wr = 1'b1;
                        taken = 1'b1;
                        res = pc + 32'd4;
                        next_pc = (a + imm_i) & ~32'd1;
                    end
                end
                OPC_BRANCH: begin
                    case (f3)
                        3'b000: taken = (a == b);
                        3'b001: taken = (a != b);
                        3'b100: taken = ($signed(a) < $signed(b));
                        3'b101: taken = ($signed(a) >= $signed(b));
                        3'b110: taken = (a < b);
                        3'b111: taken = (a >= b);
                        default: taken = 1'b0;
                    endcase
                    if (taken)
                        next_pc = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                                        inst[11:8], 1'b0};
                end
                default: begin
                end
            endcase
            // The wrong-path word behind a redirect is still fetched
            if (taken)
                exp_addr.push_back(pc + 32'd4);
            if (wr && inst[11:7] != 5'd0) begin
                x[inst[11:7]] = res;
                exp_wb.push_back({inst[11:7], res});
            end
            pc = next_pc;
            steps++;
        end
    endtask

    task automatic check_cycle();
        logic [36:0] want;
        logic [31:0] want_addr;
        if (wb_en) begin
            assert (exp_wb.size() != 0) else begin
                $display("Writeback to x%0d happened with no write pending", wb_addr);
                errors++;
            end
            if (exp_wb.size() != 0) begin
                want = exp_wb.pop_front();
                assert ({wb_addr, wb_data} == want) else begin
                    $display("ERROR at %0t ns: writeback x%0d = %h, expected x%0d = %h",
                             $time, wb_addr, wb_data, want[36:32], want[31:0]);
                    errors++;
                end
            end
        end
        if (exp_addr.size() != 0) begin
            want_addr = exp_addr.pop_front();
            assert (imem_addr == want_addr) else begin
                $display("ERROR at %0t ns: fetch address %h, expected %h",
                         $time, imem_addr, want_addr);
                errors++;
            end
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1 reset = 1'b1;
        repeat (3) begin
            @(posedge clk);
            @(negedge clk);
            assert (wb_en == 1'b0) else begin
                $display("ERROR at %0t ns: wb_en_o high during reset", $time);
                errors++;
            end
        end
        @(posedge clk);
        #1 reset = 1'b0;
    endtask

    task automatic run_test(input string name);
        int errors_before;
        int cycles;
        errors_before = errors;
        exp_wb.delete();
        exp_addr.delete();
        run_model(plen);
        apply_reset();
        cycles = 0;
        while ((exp_wb.size() != 0 || exp_addr.size() != 0) && cycles < 2 * plen + 10) begin
            @(negedge clk);
            check_cycle();
            cycles++;
        end
        // Extra cycles catch writebacks past the last expected one
        repeat (3) begin
            @(negedge clk);
            check_cycle();
        end
        assert (exp_wb.size() == 0 && exp_addr.size() == 0) else begin
            $display("Test %s ended with %0d writebacks and %0d fetches never seen",
                     name, exp_wb.size(), exp_addr.size());
            errors++;
        end
        tests_run++;
        if (errors == errors_before) begin
            $display("Test %-10s passed", name);
        end else begin
            $display("Test %-10s failed with %0d errors", name, errors - errors_before);
            tests_failed++;
        end
    endtask

    initial begin
        reset = 1'b1;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        seed = 32'hb507_622b;

        start_program();
        put(enc_i(OPC_OPI, 3'b000, 5'd1, 5'd0, 12'd5));
        put(enc_i(OPC_OPI, 3'b000, 5'd2, 5'd1, 12'hffd));
        put(enc_r(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
        run_test("reset");

        // Signed edge values first, then random ALU traffic
        start_program();
        put(enc_u(OPC_LUI, 5'd1, 20'h80000));
        put(enc_i(OPC_OPI, 3'b000, 5'd2, 5'd0, 12'hfff));
        put(enc_i(OPC_OPI, 3'b000, 5'd3, 5'd0, 12'd1));
        put(enc_r(7'h00, 3'b010, 5'd4, 5'd1, 5'd2));
        put(enc_r(7'h00, 3'b011, 5'd5, 5'd1, 5'd2));
        put(enc_r(7'h00, 3'b010, 5'd6, 5'd2, 5'd1));
        put(enc_r(7'h20, 3'b000, 5'd7, 5'd1, 5'd3));
        put(enc_r(7'h20, 3'b101, 5'd8, 5'd1, 5'd2));
        put(enc_i(OPC_OPI, 3'b101, 5'd9, 5'd1, {7'h20, 5'd4}));
        put(enc_i(OPC_OPI, 3'b101, 5'd10, 5'd1, {7'h00, 5'd4}));
        put(enc_i(OPC_OPI, 3'b010, 5'd11, 5'd1, 12'hfff));
        put(enc_i(OPC_OPI, 3'b011, 5'd12, 5'd3, 12'hfff));
        repeat (N_RANDOM) put_random_alu();
        run_test("alu");

        start_program();
        put(enc_u(OPC_LUI, 5'd5, 20'h12345));
        put(enc_i(OPC_OPI, 3'b000, 5'd5, 5'd5, 12'h678));
        put(enc_r(7'h00, 3'b000, 5'd6, 5'd5, 5'd5));
        put(enc_r(7'h20, 3'b000, 5'd7, 5'd6, 5'd5));
        put(enc_r(7'h00, 3'b100, 5'd8, 5'd7, 5'd6));
        put(enc_u(OPC_AUIPC, 5'd9, 20'h00010));
        put(enc_i(OPC_OPI, 3'b101, 5'd10, 5'd9, {7'h00, 5'd4}));
        put(enc_r(7'h00, 3'b110, 5'd11, 5'd10, 5'd8));
        put(enc_i(OPC_OPI, 3'b001, 5'd12, 5'd11, {7'h00, 5'd7}));
        put(enc_r(7'h20, 3'b101, 5'd13, 5'd12, 5'd5));
        run_test("dependent");

        // x1 = -2 and x2 = 3 split the signed and unsigned orderings
        start_program();
        put(enc_i(OPC_OPI, 3'b000, 5'd1, 5'd0, 12'hffe));
        put(enc_i(OPC_OPI, 3'b000, 5'd2, 5'd0, 12'd3));
        put_branch_trio(3'b000, 5'd1, 5'd1);
        put_branch_trio(3'b000, 5'd1, 5'd2);
        put_branch_trio(3'b001, 5'd1, 5'd2);
        put_branch_trio(3'b001, 5'd2, 5'd2);
        put_branch_trio(3'b100, 5'd1, 5'd2);
        put_branch_trio(3'b100, 5'd2, 5'd1);
        put_branch_trio(3'b101, 5'd2, 5'd1);
        put_branch_trio(3'b101, 5'd1, 5'd2);
        put_branch_trio(3'b110, 5'd2, 5'd1);
        put_branch_trio(3'b110, 5'd1, 5'd2);
        put_branch_trio(3'b111, 5'd1, 5'd2);
        put_branch_trio(3'b111, 5'd2, 5'd1);
        run_test("branch");

        start_program();
        put(enc_j(5'd1, 21'd12));
        put(enc_i(OPC_OPI, 3'b000, 5'd3, 5'd0, 12'd1));
        put(enc_i(OPC_OPI, 3'b000, 5'd3, 5'd0, 12'd2));
        put(enc_i(OPC_OPI, 3'b000, 5'd4, 5'd0, 12'd7));
        put(enc_u(OPC_AUIPC, 5'd5, 20'h00000));
        put(enc_i(OPC_JALR, 3'b000, 5'd6, 5'd5, 12'd13));
        put(enc_i(OPC_OPI, 3'b000, 5'd7, 5'd0, 12'd1));
        put(enc_j(5'd0, 21'd8));
        put(enc_i(OPC_OPI, 3'b000, 5'd8, 5'd0, 12'd1));
        put(enc_i(OPC_JALR, 3'b000, 5'd9, 5'd4, 12'd38));
        put(enc_i(OPC_OPI, 3'b000, 5'd10, 5'd0, 12'd1));
        put(enc_i(OPC_OPI, 3'b000, 5'd11, 5'd9, 12'd1));
        run_test("jump");

        start_program();
        put(enc_i(OPC_OPI, 3'b000, 5'd1, 5'd0, 12'd9));
        put(enc_i(7'b0000011, 3'b010, 5'd5, 5'd1, 12'd0));
        put({7'd0, 5'd1, 5'd0, 3'b010, 5'd4, 7'b0100011});
        put(32'h0ff0_000f);
        put(32'h0000_0073);
        put(enc_r(7'h01, 3'b000, 5'd6, 5'd1, 5'd1));
        put(enc_i(OPC_OPI, 3'b001, 5'd7, 5'd1, {7'h20, 5'd3}));
        put(enc_b(3'b010, 5'd1, 5'd1, 13'd8));
        put(enc_i(OPC_JALR, 3'b001, 5'd8, 5'd0, 12'd8));
        put(enc_i(OPC_OPI, 3'b000, 5'd0, 5'd0, 12'd5));
        put(enc_r(7'h00, 3'b000, 5'd0, 5'd1, 5'd1));
        put(enc_u(OPC_LUI, 5'd0, 20'h12345));
        put(enc_i(OPC_OPI, 3'b000, 5'd2, 5'd1, 12'd1));
        put(enc_r(7'h00, 3'b000, 5'd3, 5'd2, 5'd1));
        run_test("unsupported");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule
